/* src/pcie_meta_pkg.sv */
package pcie_meta_pkg;

    // MMIO bus geometry
    localparam int REG_SIZE = 4;
    localparam int MMIO_ADDR_WIDTH = 16;
    localparam int MMIO_DATA_WIDTH = 64;
    localparam int MMIO_BE_WIDTH = MMIO_DATA_WIDTH / 8;

    // Address decode. The page picks a packet queue or the control page
    localparam int PAGE_LSB = 12;
    localparam int PAGE_WIDTH = 4;
    localparam int MAX_NB_FLOWS = 8;
    localparam int HEAD_REG = 1;
    localparam int CTRL_PAGE = 15;
    localparam int REG_IDX_LSB = 3;
    localparam int REG_IDX_WIDTH = 3;
    localparam int NB_CONTROL_REGS = 2;

    localparam int FLOW_IDX_WIDTH = 3;
    localparam int APP_IDX_WIDTH = 3;
    localparam int PKT_SIZE_WIDTH = 16;
    localparam int REG_WIDTH = 32;
    localparam int RB_SIZE_WIDTH = 16;
    localparam int CNT_WIDTH = 32;
    localparam int OCCUP_WIDTH = 8;

    typedef logic [MMIO_ADDR_WIDTH-1:0] mmio_addr_t;
    typedef logic [MMIO_DATA_WIDTH-1:0] mmio_data_t;
    typedef logic [MMIO_BE_WIDTH-1:0] mmio_be_t;
    typedef logic [FLOW_IDX_WIDTH-1:0] flow_idx_t;
    typedef logic [APP_IDX_WIDTH-1:0] app_idx_t;
    typedef logic [PKT_SIZE_WIDTH-1:0] pkt_size_t;
    typedef logic [REG_WIDTH-1:0] reg_t;
    typedef logic [RB_SIZE_WIDTH-1:0] rb_size_t;
    typedef logic [CNT_WIDTH-1:0] cnt_t;
    typedef logic [OCCUP_WIDTH-1:0] occup_t;

    // Fields of control register 0 and 1
    localparam int DISABLE_BIT = 0;
    localparam int PKT_RB_LSB = 1;
    localparam int SW_RESET_BIT = 27;
    localparam int DSC_RB_LSB = 0;

    // Metadata word, from the top: pkt queue, dsc queue, size, descriptor_only, needs_dsc
    localparam int META_NEEDS_DSC_BIT = 0;
    localparam int META_DSC_ONLY_BIT = 1;
    localparam int META_SIZE_LSB = 2;
    localparam int META_DSC_Q_LSB = META_SIZE_LSB + PKT_SIZE_WIDTH;
    localparam int META_PKT_Q_LSB = META_DSC_Q_LSB + APP_IDX_WIDTH;
    localparam int META_WIDTH = META_PKT_Q_LSB + FLOW_IDX_WIDTH;

endpackage

/* src/ctrl_regs.sv */
`timescale 1ns/10ps

module ctrl_regs (
    input  logic                      pcie_clk,
    input  logic                      pcie_reset_n,
    input  pcie_meta_pkg::mmio_addr_t mmio_address,
    input  logic                      mmio_write,
    input  logic                      mmio_read,
    input  pcie_meta_pkg::mmio_data_t mmio_writedata,
    input  pcie_meta_pkg::mmio_be_t   mmio_byteenable,
    output pcie_meta_pkg::mmio_data_t mmio_readdata,
    output logic                      mmio_readdatavalid,
    output logic                      disable_pcie,
    output logic                      sw_reset,
    output pcie_meta_pkg::rb_size_t   pkt_rb_size,
    output pcie_meta_pkg::rb_size_t   dsc_rb_size
);
    import pcie_meta_pkg::*;

    localparam int REG_SEL_WIDTH = $clog2(NB_CONTROL_REGS);

    reg_t                     control_regs [NB_CONTROL_REGS];
    logic [PAGE_WIDTH-1:0]    page;
    logic [REG_IDX_WIDTH-1:0] reg_idx;
    logic [REG_SEL_WIDTH-1:0] reg_sel;
    logic                     ctrl_hit;
    logic                     low_lanes;
    logic                     sw_reset_r1;

    assign page = mmio_address[PAGE_LSB +: PAGE_WIDTH];
    assign reg_idx = mmio_address[REG_IDX_LSB +: REG_IDX_WIDTH];
    assign reg_sel = reg_idx[REG_SEL_WIDTH-1:0];
    assign ctrl_hit = (page == PAGE_WIDTH'(CTRL_PAGE))
        && (reg_idx < REG_IDX_WIDTH'(NB_CONTROL_REGS));
    assign low_lanes = mmio_byteenable[0 +: REG_SIZE] == {REG_SIZE{1'b1}};

    // Registers only take full 32-bit writes on lanes 0 to 3
    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            for (int i = 0; i < NB_CONTROL_REGS; i++) begin
                control_regs[i] <= '0;
            end
        end else if (mmio_write && ctrl_hit && low_lanes) begin
            control_regs[reg_sel] <= mmio_writedata[REG_WIDTH-1:0];
        end
    end

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            mmio_readdatavalid <= 1'b0;
        end else begin
            mmio_readdatavalid <= mmio_read;
        end
    end

    // Anything outside the control page reads back as zero
    always_ff @(posedge pcie_clk) begin
        if (mmio_read) begin
            mmio_readdata <= '0;
            if (ctrl_hit) begin
                mmio_readdata[REG_WIDTH-1:0] <= control_regs[reg_sel];
            end
        end
    end

    assign disable_pcie = control_regs[0][DISABLE_BIT];
    assign pkt_rb_size = control_regs[0][PKT_RB_LSB +: RB_SIZE_WIDTH];
    assign dsc_rb_size = control_regs[1][DSC_RB_LSB +: RB_SIZE_WIDTH];

    // Software sets and clears the reset bit itself, we only delay it
    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            sw_reset_r1 <= 1'b0;
            sw_reset <= 1'b0;
        end else begin
            sw_reset_r1 <= control_regs[0][SW_RESET_BIT];
            sw_reset <= sw_reset_r1;
        end
    end

endmodule

/* src/head_upd_detect.sv */
`timescale 1ns/10ps

module head_upd_detect #(
    parameter int HEAD_UPD_QUEUE_LEN = 16
) (
    input  logic                      pcie_clk,
    input  logic                      pcie_reset_n,
    input  pcie_meta_pkg::mmio_addr_t mmio_address,
    input  logic                      mmio_write,
    input  pcie_meta_pkg::mmio_be_t   mmio_byteenable,
    input  pcie_meta_pkg::occup_t     head_occup,
    output logic                      head_valid,
    output pcie_meta_pkg::flow_idx_t  head_queue,
    output pcie_meta_pkg::cnt_t       rx_ignored_head_cnt
);
    import pcie_meta_pkg::*;

    logic [PAGE_WIDTH-1:0] page;
    logic                  head_upd;
    logic                  almost_full;

    assign page = mmio_address[PAGE_LSB +: PAGE_WIDTH];

    // A head update is a write to a packet queue page covering the whole head register
    assign head_upd = mmio_write && (page < PAGE_WIDTH'(MAX_NB_FLOWS))
        && (mmio_byteenable[HEAD_REG*REG_SIZE +: REG_SIZE] == {REG_SIZE{1'b1}});

    // Margin of 4 covers the write still in flight toward the FIFO
    assign almost_full = head_occup > OCCUP_WIDTH'(HEAD_UPD_QUEUE_LEN - 4);

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            head_valid <= 1'b0;
            rx_ignored_head_cnt <= '0;
        end else begin
            head_valid <= head_upd && !almost_full;
            if (head_upd && almost_full) begin
                rx_ignored_head_cnt <= rx_ignored_head_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge pcie_clk) begin
        if (head_upd) begin
            head_queue <= page[FLOW_IDX_WIDTH-1:0];
        end
    end

endmodule

/* src/sync_fifo.sv */
`timescale 1ns/10ps

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  logic                  pcie_clk,
    input  logic                  pcie_reset_n,
    input  logic [WIDTH-1:0]      in_data,
    input  logic                  in_valid,
    output logic                  in_ready,
    output logic [WIDTH-1:0]      out_data,
    output logic                  out_valid,
    input  logic                  out_ready,
    output pcie_meta_pkg::occup_t occup
);
    import pcie_meta_pkg::*;

    localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0]     mem [DEPTH];
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    occup_t               count;
    logic                 push;
    logic                 pop;

    assign in_ready = count < OCCUP_WIDTH'(DEPTH);
    assign out_valid = count != '0;
    assign out_data = mem[rd_ptr];
    assign occup = count;

    assign push = in_valid && in_ready;
    assign pop = out_valid && out_ready;

    always_ff @(posedge pcie_clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // Pointers wrap explicitly so DEPTH need not be a power of two
    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + OCCUP_WIDTH'(push) - OCCUP_WIDTH'(pop);
        end
    end

endmodule

/* src/meta_merge_arbiter.sv */
`timescale 1ns/10ps

module meta_merge_arbiter #(
    parameter int IN_QUEUE_ALMOST = 4
) (
    input  logic                                   pcie_clk,
    input  logic                                   pcie_reset_n,
    input  logic                                   sw_reset,
    input  logic                                   head_valid,
    output logic                                   head_ready,
    input  pcie_meta_pkg::flow_idx_t               head_queue,
    input  logic                                   rx_meta_valid,
    output logic                                   rx_meta_ready,
    input  pcie_meta_pkg::flow_idx_t               rx_meta_pkt_queue,
    input  pcie_meta_pkg::app_idx_t                rx_meta_dsc_queue,
    input  pcie_meta_pkg::pkt_size_t               rx_meta_size,
    input  pcie_meta_pkg::occup_t                  order_occup,
    output logic                                   order_valid,
    output logic [pcie_meta_pkg::META_WIDTH-1:0]   order_data,
    output pcie_meta_pkg::cnt_t                    rx_pkt_head_upd_cnt
);
    import pcie_meta_pkg::*;

    logic order_room;
    logic head_pop;
    logic meta_take;
    logic merge;

    // The occupancy check is registered. With one word in flight the ordering
    // FIFO peaks at IN_QUEUE_ALMOST + 3 entries, so a depth of 8 never fills
    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            order_room <= 1'b0;
        end else begin
            order_room <= order_occup <= OCCUP_WIDTH'(IN_QUEUE_ALMOST);
        end
    end

    // Head updates go first. A packet for the same queue rides along with the
    // waiting head update, any other packet has to wait for it to drain
    always_comb begin
        head_ready = order_room;
        rx_meta_ready = order_room && (!head_valid || (rx_meta_pkt_queue == head_queue));
    end

    assign head_pop = head_valid && head_ready;
    assign meta_take = rx_meta_valid && rx_meta_ready;
    assign merge = head_pop && meta_take;

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            order_valid <= 1'b0;
        end else begin
            order_valid <= head_pop || meta_take;
        end
    end

    // Building the word here keeps descriptor-only entries in order with packets
    always_ff @(posedge pcie_clk) begin
        if (meta_take) begin
            order_data[META_PKT_Q_LSB +: FLOW_IDX_WIDTH] <= rx_meta_pkt_queue;
            order_data[META_DSC_Q_LSB +: APP_IDX_WIDTH] <= rx_meta_dsc_queue;
            order_data[META_SIZE_LSB +: PKT_SIZE_WIDTH] <= rx_meta_size;
            order_data[META_DSC_ONLY_BIT] <= 1'b0;
            order_data[META_NEEDS_DSC_BIT] <= merge;
        end else if (head_pop) begin
            order_data[META_PKT_Q_LSB +: FLOW_IDX_WIDTH] <= head_queue;
            order_data[META_DSC_Q_LSB +: APP_IDX_WIDTH] <= '0;
            order_data[META_SIZE_LSB +: PKT_SIZE_WIDTH] <= '0;
            order_data[META_DSC_ONLY_BIT] <= 1'b1;
            order_data[META_NEEDS_DSC_BIT] <= 1'b0;
        end
    end

    // Merged updates count as well
    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n || sw_reset) begin
            rx_pkt_head_upd_cnt <= '0;
        end else if (head_pop) begin
            rx_pkt_head_upd_cnt <= rx_pkt_head_upd_cnt + 1'b1;
        end
    end

endmodule

/* src/pcie_rx_meta_top.sv */
`timescale 1ns/10ps

module pcie_rx_meta_top #(
    parameter int HEAD_UPD_QUEUE_LEN = 16,
    parameter int ORDER_QUEUE_DEPTH = 8,
    parameter int IN_QUEUE_ALMOST = 4
) (
    input  logic                      pcie_clk,
    input  logic                      pcie_reset_n,

    input  pcie_meta_pkg::mmio_addr_t mmio_address,
    input  logic                      mmio_write,
    input  logic                      mmio_read,
    input  pcie_meta_pkg::mmio_data_t mmio_writedata,
    input  pcie_meta_pkg::mmio_be_t   mmio_byteenable,
    output pcie_meta_pkg::mmio_data_t mmio_readdata,
    output logic                      mmio_readdatavalid,

    input  logic                      rx_meta_valid,
    output logic                      rx_meta_ready,
    input  pcie_meta_pkg::flow_idx_t  rx_meta_pkt_queue,
    input  pcie_meta_pkg::app_idx_t   rx_meta_dsc_queue,
    input  pcie_meta_pkg::pkt_size_t  rx_meta_size,

    output logic                      out_meta_valid,
    input  logic                      out_meta_ready,
    output pcie_meta_pkg::flow_idx_t  out_meta_pkt_queue,
    output pcie_meta_pkg::app_idx_t   out_meta_dsc_queue,
    output pcie_meta_pkg::pkt_size_t  out_meta_size,
    output logic                      out_meta_descriptor_only,
    output logic                      out_meta_needs_dsc,

    output logic                      disable_pcie,
    output logic                      sw_reset,
    output pcie_meta_pkg::rb_size_t   pkt_rb_size,
    output pcie_meta_pkg::rb_size_t   dsc_rb_size,
    output pcie_meta_pkg::cnt_t       rx_ignored_head_cnt,
    output pcie_meta_pkg::cnt_t       rx_pkt_head_upd_cnt
);
    import pcie_meta_pkg::*;

    logic                  head_in_valid;
    flow_idx_t             head_in_queue;
    occup_t                head_occup;
    logic                  head_out_valid;
    logic                  head_out_ready;
    flow_idx_t             head_out_queue;

    logic                  order_in_valid;
    logic [META_WIDTH-1:0] order_in_data;
    occup_t                order_occup;
    logic [META_WIDTH-1:0] order_out_data;

    ctrl_regs u_ctrl_regs (
        .pcie_clk           (pcie_clk),
        .pcie_reset_n       (pcie_reset_n),
        .mmio_address       (mmio_address),
        .mmio_write         (mmio_write),
        .mmio_read          (mmio_read),
        .mmio_writedata     (mmio_writedata),
        .mmio_byteenable    (mmio_byteenable),
        .mmio_readdata      (mmio_readdata),
        .mmio_readdatavalid (mmio_readdatavalid),
        .disable_pcie       (disable_pcie),
        .sw_reset           (sw_reset),
        .pkt_rb_size        (pkt_rb_size),
        .dsc_rb_size        (dsc_rb_size)
    );

    head_upd_detect #(
        .HEAD_UPD_QUEUE_LEN (HEAD_UPD_QUEUE_LEN)
    ) u_head_upd_detect (
        .pcie_clk            (pcie_clk),
        .pcie_reset_n        (pcie_reset_n),
        .mmio_address        (mmio_address),
        .mmio_write          (mmio_write),
        .mmio_byteenable     (mmio_byteenable),
        .head_occup          (head_occup),
        .head_valid          (head_in_valid),
        .head_queue          (head_in_queue),
        .rx_ignored_head_cnt (rx_ignored_head_cnt)
    );

    // Both FIFOs are kept from filling by their occupancy checks upstream
    sync_fifo #(
        .WIDTH (FLOW_IDX_WIDTH),
        .DEPTH (HEAD_UPD_QUEUE_LEN)
    ) u_head_fifo (
        .pcie_clk     (pcie_clk),
        .pcie_reset_n (pcie_reset_n),
        .in_data      (head_in_queue),
        .in_valid     (head_in_valid),
        .in_ready     (),
        .out_data     (head_out_queue),
        .out_valid    (head_out_valid),
        .out_ready    (head_out_ready),
        .occup        (head_occup)
    );

    meta_merge_arbiter #(
        .IN_QUEUE_ALMOST (IN_QUEUE_ALMOST)
    ) u_meta_merge_arbiter (
        .pcie_clk            (pcie_clk),
        .pcie_reset_n        (pcie_reset_n),
        .sw_reset            (sw_reset),
        .head_valid          (head_out_valid),
        .head_ready          (head_out_ready),
        .head_queue          (head_out_queue),
        .rx_meta_valid       (rx_meta_valid),
        .rx_meta_ready       (rx_meta_ready),
        .rx_meta_pkt_queue   (rx_meta_pkt_queue),
        .rx_meta_dsc_queue   (rx_meta_dsc_queue),
        .rx_meta_size        (rx_meta_size),
        .order_occup         (order_occup),
        .order_valid         (order_in_valid),
        .order_data          (order_in_data),
        .rx_pkt_head_upd_cnt (rx_pkt_head_upd_cnt)
    );

    sync_fifo #(
        .WIDTH (META_WIDTH),
        .DEPTH (ORDER_QUEUE_DEPTH)
    ) u_order_fifo (
        .pcie_clk     (pcie_clk),
        .pcie_reset_n (pcie_reset_n),
        .in_data      (order_in_data),
        .in_valid     (order_in_valid),
        .in_ready     (),
        .out_data     (order_out_data),
        .out_valid    (out_meta_valid),
        .out_ready    (out_meta_ready),
        .occup        (order_occup)
    );

    assign out_meta_pkt_queue = order_out_data[META_PKT_Q_LSB +: FLOW_IDX_WIDTH];
    assign out_meta_dsc_queue = order_out_data[META_DSC_Q_LSB +: APP_IDX_WIDTH];
    assign out_meta_size = order_out_data[META_SIZE_LSB +: PKT_SIZE_WIDTH];
    assign out_meta_descriptor_only = order_out_data[META_DSC_ONLY_BIT];
    assign out_meta_needs_dsc = order_out_data[META_NEEDS_DSC_BIT];

endmodule

/* testbench/rx_meta_model.sv */
package rx_meta_model;

    import pcie_meta_pkg::*;

    // A head write that finds no more than this many heads outstanding is always kept
    localparam int HEAD_KEEP_LIMIT = 12;

    // Packets accepted on the rx side, in arrival order
    flow_idx_t exp_pkt_q[$];
    app_idx_t  exp_dsc_q[$];
    pkt_size_t exp_size_q[$];

    // Head writes that qualified, not yet seen at the output or counted as dropped
    flow_idx_t pend_head_q[$];
    bit        pend_drop_q[$];

    cnt_t exp_ignored;
    cnt_t exp_upd;
    reg_t shadow_regs [NB_CONTROL_REGS];

    function automatic void init_model();
        exp_pkt_q.delete();
        exp_dsc_q.delete();
        exp_size_q.delete();
        pend_head_q.delete();
        pend_drop_q.delete();
        exp_ignored = '0;
        exp_upd = '0;
        for (int i = 0; i < NB_CONTROL_REGS; i++) begin
            shadow_regs[i] = '0;
        end
    endfunction

    function automatic bit is_head_write(mmio_addr_t addr, mmio_be_t be);
        return (int'(addr[PAGE_LSB +: PAGE_WIDTH]) < MAX_NB_FLOWS) && (be[7:4] == 4'hf);
    endfunction

    function automatic bit is_ctrl_reg(mmio_addr_t addr);
        return (int'(addr[PAGE_LSB +: PAGE_WIDTH]) == CTRL_PAGE)
            && (int'(addr[REG_IDX_LSB +: REG_IDX_WIDTH]) < NB_CONTROL_REGS);
    endfunction

    function automatic void apply_ctrl_write(mmio_addr_t addr, mmio_data_t data, mmio_be_t be);
        if (is_ctrl_reg(addr) && (be[3:0] == 4'hf)) begin
            shadow_regs[addr[REG_IDX_LSB]] = data[REG_WIDTH-1:0];
        end
    endfunction

    function automatic mmio_data_t expected_read(mmio_addr_t addr);
        if (is_ctrl_reg(addr)) begin
            return {32'h0, shadow_regs[addr[REG_IDX_LSB]]};
        end
        return '0;
    endfunction

    // The outstanding count bounds the head FIFO occupancy seen by this write
    function automatic void add_head(flow_idx_t q);
        pend_drop_q.push_back(pend_head_q.size() > HEAD_KEEP_LIMIT);
        pend_head_q.push_back(q);
    endfunction

    function automatic void record_packet(flow_idx_t q, app_idx_t d, pkt_size_t s);
        exp_pkt_q.push_back(q);
        exp_dsc_q.push_back(d);
        exp_size_q.push_back(s);
    endfunction

    function automatic bit pop_packet(output flow_idx_t q, output app_idx_t d,
                                      output pkt_size_t s);
        if (exp_pkt_q.size() == 0) begin
            return 0;
        end
        q = exp_pkt_q.pop_front();
        d = exp_dsc_q.pop_front();
        s = exp_size_q.pop_front();
        return 1;
    endfunction

    // Head updates leave in write order. Entries that may have been dropped are
    // skipped until one matches, and the first surely kept entry is the expected one
    function automatic bit next_head(flow_idx_t q, output flow_idx_t exp_q);
        flow_idx_t front;
        bit        may_drop;
        exp_q = '0;
        while (pend_head_q.size() > 0) begin
            front = pend_head_q.pop_front();
            may_drop = pend_drop_q.pop_front();
            if (front == q || !may_drop) begin
                exp_q = front;
                exp_upd = exp_upd + 1;
                return 1;
            end
            exp_ignored = exp_ignored + 1;
        end
        return 0;
    endfunction

    // Once the DUT is idle, whatever is still pending was dropped
    function automatic bit flush_heads();
        bit all_droppable;
        all_droppable = 1;
        foreach (pend_drop_q[i]) begin
            if (!pend_drop_q[i]) begin
                all_droppable = 0;
            end
        end
        exp_ignored = exp_ignored + cnt_t'(pend_head_q.size());
        pend_head_q.delete();
        pend_drop_q.delete();
        return all_droppable;
    endfunction

endpackage

/* testbench/tb_pcie_rx_meta.sv */
`timescale 1ns/10ps

module tb_pcie_rx_meta;
    import pcie_meta_pkg::*;
    import rx_meta_model::*;

    localparam int CLK_PERIOD = 20;
    localparam int NB_REG_WRITES = 20;
    localparam int NB_HEAD_WRITES = 40;
    localparam int NB_PACKETS = 60;
    localparam int NB_MIXED_HEADS = 30;
    localparam int NB_TRANS = 2 * NB_REG_WRITES + 2 * NB_HEAD_WRITES + NB_PACKETS
        + NB_MIXED_HEADS + 20;

    logic       pcie_clk = 1'b0;
    logic       pcie_reset_n;
    mmio_addr_t mmio_address;
    logic       mmio_write;
    logic       mmio_read;
    mmio_data_t mmio_writedata;
    mmio_be_t   mmio_byteenable;
    mmio_data_t mmio_readdata;
    logic       mmio_readdatavalid;
    logic       rx_meta_valid;
    logic       rx_meta_ready;
    flow_idx_t  rx_meta_pkt_queue;
    app_idx_t   rx_meta_dsc_queue;
    pkt_size_t  rx_meta_size;
    logic       out_meta_valid;
    logic       out_meta_ready;
    flow_idx_t  out_meta_pkt_queue;
    app_idx_t   out_meta_dsc_queue;
    pkt_size_t  out_meta_size;
    logic       out_meta_descriptor_only;
    logic       out_meta_needs_dsc;
    logic       disable_pcie;
    logic       sw_reset;
    rb_size_t   pkt_rb_size;
    rb_size_t   dsc_rb_size;
    cnt_t       rx_ignored_head_cnt;
    cnt_t       rx_pkt_head_upd_cnt;
    int         error_count = 0;
    logic       pkts_done;

    pcie_rx_meta_top u_pcie_rx_meta_top (.*);

    always #(CLK_PERIOD / 2) pcie_clk = ~pcie_clk;

    task automatic report_failure(string msg);
        error_count++;
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_meta(string what, flow_idx_t got_q, flow_idx_t exp_q, app_idx_t got_d,
                              app_idx_t exp_d, pkt_size_t got_s, pkt_size_t exp_s);
        if (got_q !== exp_q || got_d !== exp_d || got_s !== exp_s) begin
            report_failure($sformatf(
                "Mismatch at %0t: %s got q%0d d%0d size %0d, expected q%0d d%0d size %0d",
                $time, what, got_q, got_d, got_s, exp_q, exp_d, exp_s));
        end
    endtask

    task automatic check_reg(string what, mmio_data_t got, mmio_data_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0t: %s got %h expected %h",
                $time, what, got, exp));
        end
    endtask

    task automatic check_cnt(string what, cnt_t got, cnt_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0t: %s got %0d expected %0d",
                $time, what, got, exp));
        end
    endtask

    task automatic check_size(string what, rb_size_t got, rb_size_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0t: %s got %h expected %h",
                $time, what, got, exp));
        end
    endtask

    task automatic check_flag(string what, logic got, logic exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch at %0t: %s got %b expected %b",
                $time, what, got, exp));
        end
    endtask

    // All tasks start and end 2 ns after a rising edge
    task automatic mmio_write_word(mmio_addr_t addr, mmio_data_t data, mmio_be_t be);
        mmio_address = addr;
        mmio_writedata = data;
        mmio_byteenable = be;
        mmio_write = 1'b1;
        if (is_head_write(addr, be)) begin
            add_head(flow_idx_t'(addr[PAGE_LSB +: FLOW_IDX_WIDTH]));
        end
        apply_ctrl_write(addr, data, be);
        @(posedge pcie_clk);
        #2;
        mmio_write = 1'b0;
    endtask

    task automatic mmio_read_check(mmio_addr_t addr);
        mmio_address = addr;
        mmio_read = 1'b1;
        @(posedge pcie_clk);
        #2;
        mmio_read = 1'b0;
        if (mmio_readdatavalid !== 1'b1) begin
            report_failure("Read data valid did not follow the read strobe by one cycle");
        end
        check_reg("mmio_readdata", mmio_readdata, expected_read(addr));
    endtask

    task automatic head_write_random(int max_page, int partial_be);
        int       page;
        mmio_be_t be;
        page = int'($urandom_range(0, max_page));
        be = 8'hff;
        if (partial_be != 0) begin
            be = mmio_be_t'($urandom());
        end
        mmio_write_word(mmio_addr_t'((page << PAGE_LSB) + HEAD_REG * REG_SIZE),
                        {$urandom(), $urandom()}, be);
    endtask

    task automatic send_packets(int n, int max_q);
        int gap;
        for (int i = 0; i < n; i++) begin
            gap = int'($urandom_range(0, 2));
            repeat (gap) begin
                @(posedge pcie_clk);
                #2;
            end
            rx_meta_pkt_queue = flow_idx_t'($urandom_range(0, max_q));
            rx_meta_dsc_queue = app_idx_t'($urandom());
            rx_meta_size = pkt_size_t'($urandom());
            rx_meta_valid = 1'b1;
            do @(negedge pcie_clk); while (!rx_meta_ready);
            @(posedge pcie_clk);
            #2;
            rx_meta_valid = 1'b0;
        end
    endtask

    task automatic check_output();
        flow_idx_t q;
        app_idx_t  d;
        pkt_size_t s;
        flow_idx_t hq;
        if (out_meta_descriptor_only) begin
            if (!next_head(out_meta_pkt_queue, hq)) begin
                report_failure("Descriptor-only word appeared with no matching head write");
            end
            check_meta("descriptor-only word", out_meta_pkt_queue, hq,
                       out_meta_dsc_queue, '0, out_meta_size, '0);
            check_flag("needs_dsc of descriptor-only word", out_meta_needs_dsc, 1'b0);
        end else begin
            if (!pop_packet(q, d, s)) begin
                report_failure("Packet word appeared with no packet accepted");
            end
            check_meta("packet word", out_meta_pkt_queue, q, out_meta_dsc_queue, d,
                       out_meta_size, s);
            if (out_meta_needs_dsc) begin
                if (!next_head(out_meta_pkt_queue, hq)) begin
                    report_failure("Merged packet word has no matching head write");
                end
                check_meta("merged head update", out_meta_pkt_queue, hq,
                           out_meta_dsc_queue, d, out_meta_size, s);
            end
        end
    endtask

    // Handshakes are sampled mid-cycle where every signal is stable
    always @(negedge pcie_clk) begin
        if (pcie_reset_n) begin
            if (rx_meta_valid && rx_meta_ready) begin
                record_packet(rx_meta_pkt_queue, rx_meta_dsc_queue, rx_meta_size);
            end
            if (out_meta_valid && out_meta_ready) begin
                check_output();
            end
        end
    end

    task automatic drain_and_check();
        int idle;
        idle = 0;
        out_meta_ready = 1'b1;
        while (idle < 20) begin
            @(posedge pcie_clk);
            #2;
            idle = out_meta_valid ? 0 : idle + 1;
        end
        if (!flush_heads()) begin
            report_failure("A head write that could not be dropped never came out");
        end
        if (exp_pkt_q.size() != 0) begin
            report_failure("Accepted packets never came out of the DUT");
        end
        check_cnt("rx_ignored_head_cnt", rx_ignored_head_cnt, exp_ignored);
        check_cnt("rx_pkt_head_upd_cnt", rx_pkt_head_upd_cnt, exp_upd);
    endtask

    initial begin
        #(NB_TRANS * 40 * CLK_PERIOD);
        report_failure("Timeout: the tests did not finish in the expected time");
    end

    initial begin
        mmio_data_t data;
        mmio_addr_t addr;
        mmio_be_t   be;
        void'($urandom(32'h7e95_de5e));
        init_model();
        pcie_reset_n = 1'b0;
        mmio_address = '0;
        mmio_write = 1'b0;
        mmio_read = 1'b0;
        mmio_writedata = '0;
        mmio_byteenable = '0;
        rx_meta_valid = 1'b0;
        rx_meta_pkt_queue = '0;
        rx_meta_dsc_queue = '0;
        rx_meta_size = '0;
        out_meta_ready = 1'b1;
        pkts_done = 1'b0;
        repeat (16) @(posedge pcie_clk);
        #2;
        pcie_reset_n = 1'b1;
        check_flag("out_meta_valid after reset", out_meta_valid, 1'b0);
        check_flag("rx_meta_ready after reset", rx_meta_ready, 1'b0);
        check_flag("mmio_readdatavalid after reset", mmio_readdatavalid, 1'b0);
        check_cnt("rx_ignored_head_cnt after reset", rx_ignored_head_cnt, '0);
        check_cnt("rx_pkt_head_upd_cnt after reset", rx_pkt_head_upd_cnt, '0);

        for (int i = 0; i < NB_REG_WRITES; i++) begin
            addr = mmio_addr_t'((CTRL_PAGE << PAGE_LSB) + $urandom_range(0, 1) * 8);
            data = {$urandom(), $urandom() & ~(32'h1 << SW_RESET_BIT)};
            be = ($urandom_range(0, 3) == 0) ? mmio_be_t'($urandom()) : 8'hff;
            mmio_write_word(addr, data, be);
            mmio_read_check(addr);
            check_flag("disable_pcie", disable_pcie, shadow_regs[0][DISABLE_BIT]);
            check_size("pkt_rb_size", pkt_rb_size, shadow_regs[0][PKT_RB_LSB +: RB_SIZE_WIDTH]);
            check_size("dsc_rb_size", dsc_rb_size, shadow_regs[1][DSC_RB_LSB +: RB_SIZE_WIDTH]);
        end
        mmio_read_check(mmio_addr_t'(3 << PAGE_LSB));

        for (int i = 0; i < NB_HEAD_WRITES; i++) begin
            head_write_random(14, int'($urandom_range(0, 1)));
        end
        drain_and_check();

        out_meta_ready = 1'b0;
        for (int i = 0; i < NB_HEAD_WRITES; i++) begin
            head_write_random(7, 0);
        end
        if (rx_ignored_head_cnt == exp_ignored) begin
            report_failure("Back-pressure did not cause any dropped head update");
        end
        drain_and_check();

        // Software reset clears only the head update counter
        mmio_write_word(mmio_addr_t'(CTRL_PAGE << PAGE_LSB),
                        {32'h0, shadow_regs[0] | (32'h1 << SW_RESET_BIT)}, 8'hff);
        check_flag("sw_reset at write", sw_reset, 1'b0);
        @(posedge pcie_clk);
        #2;
        check_flag("sw_reset one cycle after write", sw_reset, 1'b0);
        @(posedge pcie_clk);
        #2;
        check_flag("sw_reset two cycles after write", sw_reset, 1'b1);
        @(posedge pcie_clk);
        #2;
        exp_upd = '0;
        check_cnt("rx_pkt_head_upd_cnt in sw reset", rx_pkt_head_upd_cnt, exp_upd);
        check_cnt("rx_ignored_head_cnt in sw reset", rx_ignored_head_cnt, exp_ignored);
        mmio_write_word(mmio_addr_t'(CTRL_PAGE << PAGE_LSB),
                        {32'h0, shadow_regs[0] & ~(32'h1 << SW_RESET_BIT)}, 8'hff);
        repeat (3) begin
            @(posedge pcie_clk);
            #2;
        end
        check_flag("sw_reset after release", sw_reset, 1'b0);

        fork
            begin
                send_packets(NB_PACKETS, 1);
                pkts_done = 1'b1;
            end
            begin
                for (int i = 0; i < NB_MIXED_HEADS; i++) begin
                    head_write_random(1, 0);
                    repeat ($urandom_range(0, 3)) begin
                        @(posedge pcie_clk);
                        #2;
                    end
                end
            end
            begin
                while (!pkts_done) begin
                    out_meta_ready = ($urandom_range(0, 3) != 0);
                    @(posedge pcie_clk);
                    #2;
                end
                out_meta_ready = 1'b1;
            end
        join
        drain_and_check();

        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* pcie_rx_meta.f */
src/pcie_meta_pkg.sv
src/ctrl_regs.sv
src/head_upd_detect.sv
src/sync_fifo.sv
src/meta_merge_arbiter.sv
src/pcie_rx_meta_top.sv
testbench/rx_meta_model.sv
testbench/tb_pcie_rx_meta.sv

/* Makefile */
TOP := tb_pcie_rx_meta

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f pcie_rx_meta.f --top-module $(TOP)

sim:
	verilator --binary --timing -j 0 -f pcie_rx_meta.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Finished with no errors$$"

clean:
	rm -rf obj_dir
